// ==== Makefile ====
TOP := tb_lsu_mpu

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -j 0 -f sim.f --top-module $(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "Test FAILED" sim.log; then exit 1; fi
	@grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== logic/lsu_mpu.sv ====
// Protection stage between the core request port and the bus port
// Good requests pass straight through with their memory attributes attached
// Faulting requests are held off the bus and answered locally once every
// earlier access has completed
`timescale 1ns/1ps
`default_nettype none

module lsu_mpu import lsu_mpu_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  // Core side
  input  logic       core_req_valid_i,
  input  core_req_t  core_req_i,
  output logic       core_req_ready_o,
  output logic       core_resp_valid_o,
  output core_resp_t core_resp_o,
  // Bus side
  output logic       bus_req_valid_o,
  output bus_req_t   bus_req_o,
  input  logic       bus_req_ready_i,
  input  logic       bus_resp_valid_i,
  input  bus_resp_t  bus_resp_i,
  // From the tracker
  input  logic       one_pend_n_i
);

  mpu_state_e  state_q;
  mpu_state_e  state_n;
  logic        pma_err;
  memtype_t    memtype;
  logic        block_core;
  logic        block_bus;
  logic        fault_valid;
  mpu_status_e mpu_status;

  ////////////////////
  // Fault FSM
  ////////////////////

  // A faulting request is swallowed in the cycle it would be accepted
  // Then wait until only that request is left before answering it
  always_comb begin
    state_n     = state_q;
    block_core  = 1'b0;
    block_bus   = 1'b0;
    fault_valid = 1'b0;
    mpu_status  = MPU_OK;
    case (state_q)
      MPU_IDLE: begin
        if (pma_err && core_req_valid_i) begin
          // Never on the bus, also while the bus is stalling
          block_bus = 1'b1;
          if (bus_req_ready_i) begin
            // Still accepted from the core
            if (core_req_i.we) begin
              state_n = one_pend_n_i ? MPU_WR_ERR_RESP : MPU_WR_ERR_WAIT;
            end else begin
              state_n = one_pend_n_i ? MPU_RE_ERR_RESP : MPU_RE_ERR_WAIT;
            end
          end
        end
      end
      MPU_RE_ERR_WAIT, MPU_WR_ERR_WAIT: begin
        // Earlier accesses still in flight
        block_core = 1'b1;
        block_bus  = 1'b1;
        if (one_pend_n_i) begin
          state_n = (state_q == MPU_RE_ERR_WAIT) ? MPU_RE_ERR_RESP : MPU_WR_ERR_RESP;
        end
      end
      MPU_RE_ERR_RESP, MPU_WR_ERR_RESP: begin
        block_core  = 1'b1;
        block_bus   = 1'b1;
        // Local answer toward the core
        fault_valid = 1'b1;
        mpu_status  = (state_q == MPU_RE_ERR_RESP) ? MPU_RE_FAULT : MPU_WR_FAULT;
        state_n     = MPU_IDLE;
      end
      default: begin
        state_n = MPU_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MPU_IDLE;
    end else begin
      state_q <= state_n;
    end
  end

  ////////////////////
  // Request path
  ////////////////////

  assign bus_req_valid_o  = core_req_valid_i && !block_bus;
  assign core_req_ready_o = bus_req_ready_i && !block_core;

  // Copy of the core request plus attributes
  always_comb begin
    bus_req_o.addr    = core_req_i.addr;
    bus_req_o.we      = core_req_i.we;
    bus_req_o.be      = core_req_i.be;
    bus_req_o.wdata   = core_req_i.wdata;
    bus_req_o.atomic  = core_req_i.atomic;
    bus_req_o.memtype = memtype;
  end

  ////////////////////
  // Response path
  ////////////////////

  // Never both at once since the FSM waits out all bus traffic
  assign core_resp_valid_o      = bus_resp_valid_i || fault_valid;
  assign core_resp_o.bus_resp   = bus_resp_i;
  assign core_resp_o.mpu_status = mpu_status;

  // Attribute lookup
  pma_checker u_pma_checker (
    .addr_i    (core_req_i.addr),
    .atomic_i  (core_req_i.atomic),
    .pma_err_o (pma_err),
    .memtype_o (memtype)
  );

endmodule

`default_nettype wire

// ==== logic/lsu_mpu_defs.svh ====
// Global sizes for the data-side memory protection path
// Include before the package and in any module that sizes itself from these
`ifndef LSU_MPU_DEFS_SVH
`define LSU_MPU_DEFS_SVH

////////////////////
// Datapath widths
////////////////////

// Physical address width
`define LSU_ADDR_W 32

// Load and store data width
`define LSU_DATA_W 32

////////////////////
// Sizing
////////////////////

// Entries in the attribute region table
`define LSU_PMA_REGIONS 4

// Most accesses in flight between core and bus
`define LSU_MAX_OUTSTANDING 4

`endif

// ==== logic/lsu_mpu_pkg.sv ====
// Shared types for the load/store protection path
// Holds the request and response structs, the FSM and status enums and the region table
`default_nettype none

`include "lsu_mpu_defs.svh"

package lsu_mpu_pkg;

  ////////////////////
  // Plain vectors
  ////////////////////

  typedef logic [`LSU_ADDR_W-1:0] addr_t;
  typedef logic [`LSU_DATA_W-1:0] data_t;

  // Must hold the value LSU_MAX_OUTSTANDING itself
  typedef logic [$clog2(`LSU_MAX_OUTSTANDING+1)-1:0] pend_cnt_t;

  // Bit 1 cacheable, bit 0 bufferable
  typedef logic [1:0] memtype_t;

  ////////////////////
  // Bus structs
  ////////////////////

  // Request from the core side
  typedef struct packed {
    addr_t       addr;
    logic        we;
    logic [3:0]  be;
    data_t       wdata;
    logic        atomic;
  } core_req_t;

  // Same request tagged with attributes for the bus
  typedef struct packed {
    addr_t       addr;
    logic        we;
    logic [3:0]  be;
    data_t       wdata;
    logic        atomic;
    memtype_t    memtype;
  } bus_req_t;

  typedef struct packed {
    data_t       rdata;
    logic        err;
  } bus_resp_t;

  typedef enum logic [1:0] {
    MPU_OK,
    MPU_RE_FAULT,
    MPU_WR_FAULT
  } mpu_status_e;

  typedef struct packed {
    bus_resp_t   bus_resp;
    mpu_status_e mpu_status;
  } core_resp_t;

  ////////////////////
  // Protection
  ////////////////////

  // Hit when (addr & mask) == base
  typedef struct packed {
    addr_t       base;
    addr_t       mask;
    logic        main;
    logic        bufferable;
    logic        cacheable;
  } pma_region_t;

  typedef enum logic [2:0] {
    MPU_IDLE,
    MPU_RE_ERR_WAIT,
    MPU_WR_ERR_WAIT,
    MPU_RE_ERR_RESP,
    MPU_WR_ERR_RESP
  } mpu_state_e;

  // Fixed region map, lowest index has priority
  localparam pma_region_t PMA_TABLE [0:`LSU_PMA_REGIONS-1] = '{
    // Main RAM, 64 KiB
    '{base: 32'h0000_0000, mask: 32'hFFFF_0000, main: 1'b1, bufferable: 1'b1, cacheable: 1'b1},
    // Main ROM, 64 KiB
    '{base: 32'h1000_0000, mask: 32'hFFFF_0000, main: 1'b1, bufferable: 1'b0, cacheable: 1'b1},
    // Peripheral I/O, 4 KiB
    '{base: 32'h2000_0000, mask: 32'hFFFF_F000, main: 1'b0, bufferable: 1'b0, cacheable: 1'b0},
    // Second I/O window, 4 KiB
    '{base: 32'h3000_0000, mask: 32'hFFFF_F000, main: 1'b0, bufferable: 1'b0, cacheable: 1'b0}
  };

endpackage

`default_nettype wire

// ==== logic/lsu_mpu_top.sv ====
// Data-side protection subsystem top level
// Core port in, bus port out, with the tracker watching the core-side handshake
// and feeding its look-ahead count to the protection stage
`timescale 1ns/1ps
`default_nettype none

module lsu_mpu_top import lsu_mpu_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  // Core side
  input  logic       core_req_valid_i,
  input  core_req_t  core_req_i,
  output logic       core_req_ready_o,
  output logic       core_resp_valid_o,
  output core_resp_t core_resp_o,
  // Bus side
  output logic       bus_req_valid_o,
  output bus_req_t   bus_req_o,
  input  logic       bus_req_ready_i,
  input  logic       bus_resp_valid_i,
  input  bus_resp_t  bus_resp_i
);

  // Exactly one access left after this cycle
  logic one_pend_n;

  ////////////////////
  // Tracker
  ////////////////////

  // Observes the same handshake the core sees
  txn_tracker u_txn_tracker (
    .clk               (clk),
    .rst_n             (rst_n),
    .core_req_valid_i  (core_req_valid_i),
    .core_req_ready_i  (core_req_ready_o),
    .core_resp_valid_i (core_resp_valid_o),
    .one_pend_n_o      (one_pend_n)
  );

  ////////////////////
  // Protection stage
  ////////////////////

  lsu_mpu u_lsu_mpu (
    .clk               (clk),
    .rst_n             (rst_n),
    .core_req_valid_i  (core_req_valid_i),
    .core_req_i        (core_req_i),
    .core_req_ready_o  (core_req_ready_o),
    .core_resp_valid_o (core_resp_valid_o),
    .core_resp_o       (core_resp_o),
    .bus_req_valid_o   (bus_req_valid_o),
    .bus_req_o         (bus_req_o),
    .bus_req_ready_i   (bus_req_ready_i),
    .bus_resp_valid_i  (bus_resp_valid_i),
    .bus_resp_i        (bus_resp_i),
    .one_pend_n_i      (one_pend_n)
  );

endmodule

`default_nettype wire

// ==== logic/pma_checker.sv ====
// Physical memory attribute lookup for one data address
// Purely combinational and used by the protection stage on every core request
`timescale 1ns/1ps
`default_nettype none

`include "lsu_mpu_defs.svh"

module pma_checker import lsu_mpu_pkg::*; #(
  parameter int NUM_REGIONS = `LSU_PMA_REGIONS
) (
  input  addr_t    addr_i,
  input  logic     atomic_i,
  output logic     pma_err_o,
  output memtype_t memtype_o
);

  ////////////////////
  // Region match
  ////////////////////

  logic        hit;
  pma_region_t region;

  // Walk from index 0 and stop taking matches after the first one
  always_comb begin
    hit    = 1'b0;
    region = '0;
    for (int i = 0; i < NUM_REGIONS; i++) begin
      if (!hit && ((addr_i & PMA_TABLE[i].mask) == PMA_TABLE[i].base)) begin
        hit    = 1'b1;
        region = PMA_TABLE[i];
      end
    end
  end

  ////////////////////
  // Verdict
  ////////////////////

  // Unmapped address always faults
  // Atomics are only legal in main memory
  assign pma_err_o = !hit || (atomic_i && !region.main);

  // Attributes only reported for a legal access
  always_comb begin
    if (pma_err_o) begin
      memtype_o = '0;
    end else begin
      memtype_o[1] = region.cacheable;
      memtype_o[0] = region.bufferable;
    end
  end

endmodule

`default_nettype wire

// ==== logic/txn_tracker.sv ====
// Outstanding access counter on the core side of the protection stage
// Watches the request handshake and the response strobe without altering them
// and tells the protection stage when exactly one access will be left
`timescale 1ns/1ps
`default_nettype none

module txn_tracker import lsu_mpu_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic core_req_valid_i,
  input  logic core_req_ready_i,
  input  logic core_resp_valid_i,
  output logic one_pend_n_o
);

  pend_cnt_t pend_cnt_q;
  pend_cnt_t pend_cnt_n;
  logic      req_accept;

  // Request taken this cycle
  assign req_accept = core_req_valid_i && core_req_ready_i;

  // Next count after this cycle's accept and response
  // Both in the same cycle cancel out
  always_comb begin
    pend_cnt_n = pend_cnt_q;
    if (req_accept && !core_resp_valid_i) begin
      pend_cnt_n = pend_cnt_q + pend_cnt_t'(1);
    end else if (!req_accept && core_resp_valid_i) begin
      pend_cnt_n = pend_cnt_q - pend_cnt_t'(1);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pend_cnt_q <= '0;
    end else begin
      pend_cnt_q <= pend_cnt_n;
    end
  end

  // Looks ahead one cycle so the FSM can answer right after the last bus response
  assign one_pend_n_o = (pend_cnt_n == pend_cnt_t'(1));

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+logic
logic/lsu_mpu_pkg.sv
logic/pma_checker.sv
logic/txn_tracker.sv
logic/lsu_mpu.sv
logic/lsu_mpu_top.sv
tb/lsu_mpu_assertions.sv
tb/tb_lsu_mpu.sv

// ==== tb/lsu_mpu_assertions.sv ====
// Protocol checks on the protection stage
// Bound into lsu_mpu from the testbench, sees the FSM state and both strobes
`timescale 1ns/1ps
`default_nettype none

module lsu_mpu_assertions import lsu_mpu_pkg::*; (
  input logic       clk,
  input logic       rst_n,
  input mpu_state_e state_i,
  input logic       pma_err_i,
  input logic       bus_req_valid_i,
  input logic       core_req_ready_i,
  input logic       fault_valid_i,
  input logic       bus_resp_valid_i
);

  logic blocking;

  // WAIT and RESP states both hold the core off
  assign blocking = (state_i != MPU_IDLE);

  // Bus request only leaves from the idle state and never for a faulting address
  bus_valid_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
    bus_req_valid_i |-> (!blocking && !pma_err_i))
    else $error("bus request valid outside the idle state or for a faulting address");

  // Local fault answer and bus answer never share a cycle
  no_resp_collision: assert property (@(posedge clk) disable iff (!rst_n)
    !(fault_valid_i && bus_resp_valid_i))
    else $error("fault response collided with a bus response");

  no_ready_while_blocked: assert property (@(posedge clk) disable iff (!rst_n)
    blocking |-> !core_req_ready_i)
    else $error("core request ready while waiting on a fault");

endmodule

`default_nettype wire

// ==== tb/lsu_mpu_trace.txt ====
# id addr we atomic wdata status memtype rdata  (status 0 ok, 1 read fault, 2 write fault)
# addr, wdata and rdata in hex, the rest decimal; rdata is 0 for writes and faults
1 00000100 1 0 cafe0001 0 3 00000000
2 00000104 1 0 cafe0002 0 3 00000000
3 00000100 0 0 00000000 0 3 cafe0001
4 00000104 0 0 00000000 0 3 cafe0002
5 0000fffc 1 0 12345678 0 3 00000000
6 0000fffc 0 0 00000000 0 3 12345678
7 10000010 0 0 00000000 0 2 efffffef
8 10000020 0 0 00000000 0 2 efffffdf
9 20000008 1 0 a5a5a5a5 0 0 00000000
10 20000008 0 0 00000000 0 0 a5a5a5a5
11 30000ffc 0 0 00000000 0 0 cffff003
12 40000000 0 0 00000000 1 0 00000000
13 40000000 1 0 deadbeef 2 0 00000000
14 20001000 0 0 00000000 1 0 00000000
15 00010000 1 0 11111111 2 0 00000000
16 20000010 0 1 00000000 1 0 00000000
17 30000000 1 1 55aa55aa 2 0 00000000
18 00000200 1 1 0badf00d 0 3 00000000
19 00000200 0 1 00000000 0 3 0badf00d
20 10000000 0 1 00000000 0 2 efffffff
21 00000300 1 0 77770001 0 3 00000000
22 00000304 1 0 77770002 0 3 00000000
23 00000300 0 0 00000000 0 3 77770001
24 50000000 0 0 00000000 1 0 00000000
25 00000304 0 0 00000000 0 3 77770002
26 f0000000 1 0 00000000 2 0 00000000
27 00000000 0 0 00000000 0 3 ffffffff
28 10000004 0 0 00000000 0 2 effffffb

// ==== tb/tb_lsu_mpu.sv ====
// Trace-driven testbench for the data-side protection subsystem
// Replays the trace on the core port back to back, models the bus with random
// stalls and 1 to 3 cycle latency, and checks every response in request order
`timescale 1ns/1ps
`default_nettype none

`include "lsu_mpu_defs.svh"

module tb_lsu_mpu import lsu_mpu_pkg::*; ();

  localparam int          CLK_PERIOD = 40;
  localparam int unsigned RAND_SEED  = 32'h4c80_5bcd;
  localparam int          BUS_DEPTH  = `LSU_MAX_OUTSTANDING;

  // One trace line
  typedef struct packed {
    logic [15:0] id;
    addr_t       addr;
    logic        we;
    logic        atomic;
    data_t       wdata;
    mpu_status_e status;
    memtype_t    memtype;
    data_t       rdata;
  } trace_entry_t;

  logic       clk;
  logic       rst_n;
  logic       core_req_valid;
  core_req_t  core_req;
  logic       core_req_ready;
  logic       core_resp_valid;
  core_resp_t core_resp;
  logic       bus_req_valid;
  bus_req_t   bus_req;
  logic       bus_req_ready;
  logic       bus_resp_valid;
  bus_resp_t  bus_resp;

  trace_entry_t trace_q [$];
  // Trace indices of accepted requests still waiting for an answer
  int           pend_idx_q [$];
  int           cur_idx      = 0;
  int           num_done     = 0;
  int           error_count  = 0;
  int           check_count  = 0;
  bit           trace_loaded = 1'b0;

  lsu_mpu_top u_lsu_mpu_top (
    .clk               (clk),
    .rst_n             (rst_n),
    .core_req_valid_i  (core_req_valid),
    .core_req_i        (core_req),
    .core_req_ready_o  (core_req_ready),
    .core_resp_valid_o (core_resp_valid),
    .core_resp_o       (core_resp),
    .bus_req_valid_o   (bus_req_valid),
    .bus_req_o         (bus_req),
    .bus_req_ready_i   (bus_req_ready),
    .bus_resp_valid_i  (bus_resp_valid),
    .bus_resp_i        (bus_resp)
  );

  bind lsu_mpu lsu_mpu_assertions u_lsu_mpu_assertions (
    .clk              (clk),
    .rst_n            (rst_n),
    .state_i          (state_q),
    .pma_err_i        (pma_err),
    .bus_req_valid_i  (bus_req_valid_o),
    .core_req_ready_i (core_req_ready_o),
    .fault_valid_i    (fault_valid),
    .bus_resp_valid_i (bus_resp_valid_i)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  ////////////////////
  // Helpers
  ////////////////////

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected);
    end
  endtask

  task automatic load_trace(output bit ok);
    int           fd;
    int           n;
    int           v_id;
    int           v_we;
    int           v_atomic;
    int           v_status;
    int           v_memtype;
    logic [31:0]  v_addr;
    logic [31:0]  v_wdata;
    logic [31:0]  v_rdata;
    string        line;
    trace_entry_t e;
    ok = 1'b0;
    fd = $fopen("tb/lsu_mpu_trace.txt", "r");
    if (fd != 0) begin
      while ($fgets(line, fd) != 0) begin
        // Column comments and blank lines carry no access
        if (line.len() < 8 || line.getc(0) == "#") begin
          continue;
        end
        n = $sscanf(line, "%d %h %d %d %h %d %d %h", v_id, v_addr, v_we, v_atomic,
                    v_wdata, v_status, v_memtype, v_rdata);
        if (n == 8) begin
          e.id      = v_id[15:0];
          e.addr    = v_addr;
          e.we      = (v_we != 0);
          e.atomic  = (v_atomic != 0);
          e.wdata   = v_wdata;
          e.status  = mpu_status_e'(v_status[1:0]);
          e.memtype = v_memtype[1:0];
          e.rdata   = v_rdata;
          trace_q.push_back(e);
        end
      end
      $fclose(fd);
      ok = (trace_q.size() != 0);
    end
  endtask

  // Called on a falling edge, holds the request until the handshake
  // Handshake is sampled a quarter period before the rising edge
  task automatic issue_request(input int idx);
    trace_entry_t e;
    logic         accepted;
    e = trace_q[idx];
    cur_idx               = idx;
    core_req_valid        = 1'b1;
    core_req.addr         = e.addr;
    core_req.we           = e.we;
    core_req.be           = 4'hF;
    core_req.wdata        = e.wdata;
    core_req.atomic       = e.atomic;
    do begin
      #(CLK_PERIOD / 4);
      accepted = core_req_valid && core_req_ready;
      @(negedge clk);
    end while (!accepted);
  endtask

  // Good requests go out with their attributes, faulting ones never do
  task automatic record_accept();
    trace_entry_t e;
    e = trace_q[cur_idx];
    pend_idx_q.push_back(cur_idx);
    if (e.status == MPU_OK) begin
      if (!bus_req_valid) begin
        error_count++;
        $display("test %0d: good request to %h was kept off the bus", e.id, e.addr);
      end else begin
        check_value("bus_req_o.addr", bus_req.addr, e.addr);
        check_value("bus_req_o.we", 32'(bus_req.we), 32'(e.we));
        check_value("bus_req_o.be", 32'(bus_req.be), 32'h0000_000F);
        check_value("bus_req_o.wdata", bus_req.wdata, e.wdata);
        check_value("bus_req_o.atomic", 32'(bus_req.atomic), 32'(e.atomic));
        check_value("bus_req_o.memtype", 32'(bus_req.memtype), 32'(e.memtype));
      end
    end else if (bus_req_valid) begin
      error_count++;
      $display("test %0d: faulting address %h reached the bus", e.id, e.addr);
    end
  endtask

  task automatic check_response();
    trace_entry_t e;
    int           errs_before;
    if (pend_idx_q.size() == 0) begin
      error_count++;
      $display("core response arrived with no request outstanding");
      return;
    end
    e           = trace_q[pend_idx_q.pop_front()];
    errs_before = error_count;
    check_value("core_resp_o.mpu_status", 32'(core_resp.mpu_status), 32'(e.status));
    check_value("core_resp_o.bus_resp.rdata", core_resp.bus_resp.rdata, e.rdata);
    check_value("core_resp_o.bus_resp.err", 32'(core_resp.bus_resp.err), 32'h0);
    num_done++;
    $display("test %0d %s %h: %s", e.id, e.we ? "write" : "read ", e.addr,
             (error_count == errs_before) ? "ok" : "mismatch");
  endtask

  ////////////////////
  // Bus model
  ////////////////////

  // In-order memory, answers after 1 to 3 cycles, at most BUS_DEPTH in flight
  initial begin
    data_t       mem [addr_t];
    data_t       data_q [$];
    int unsigned due_q [$];
    int unsigned cycle;
    int unsigned last_due;
    int unsigned due;
    data_t       rdata;
    void'($urandom(RAND_SEED));
    cycle          = 0;
    last_due       = 0;
    bus_req_ready  = 1'b0;
    bus_resp_valid = 1'b0;
    bus_resp       = '0;
    forever begin
      @(negedge clk);
      cycle++;
      if (due_q.size() != 0 && due_q[0] <= cycle) begin
        bus_resp_valid = 1'b1;
        bus_resp.rdata = data_q.pop_front();
        bus_resp.err   = 1'b0;
        void'(due_q.pop_front());
      end else begin
        bus_resp_valid = 1'b0;
        bus_resp       = '0;
      end
      bus_req_ready = (data_q.size() < BUS_DEPTH) && (($urandom % 4) != 0);
      // Handshake of this cycle, settled before the rising edge
      #(CLK_PERIOD / 4);
      if (bus_req_valid && bus_req_ready) begin
        if (bus_req.we) begin
          mem[bus_req.addr] = bus_req.wdata;
          rdata = '0;
        end else begin
          // Unwritten words read back as the inverted address
          rdata = mem.exists(bus_req.addr) ? mem[bus_req.addr] : ~bus_req.addr;
        end
        due = cycle + 1 + ($urandom % 3);
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        data_q.push_back(rdata);
        due_q.push_back(due);
      end
    end
  end

  ////////////////////
  // Monitor
  ////////////////////

  // Samples a quarter period before each rising edge
  initial begin
    forever begin
      @(negedge clk);
      #(CLK_PERIOD / 4);
      if (rst_n) begin
        if (core_resp_valid) begin
          check_response();
        end
        if (core_req_valid && core_req_ready) begin
          record_accept();
        end
      end
    end
  end

  // Ten cycles per trace entry plus reset
  initial begin
    wait (trace_loaded);
    #((trace_q.size() * 10 + 10) * CLK_PERIOD);
    $display("Timeout: only %0d of %0d accesses answered in time", num_done, trace_q.size());
    $display("Test FAILED");
    $finish;
  end

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    bit ok;
    rst_n          = 1'b0;
    core_req_valid = 1'b0;
    core_req       = '0;
    load_trace(ok);
    if (!ok) begin
      $display("Could not read any access from the trace file");
      $display("Test FAILED");
      $finish;
    end else begin
      trace_loaded = 1'b1;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      for (int i = 0; i < trace_q.size(); i++) begin
        issue_request(i);
      end
      core_req_valid = 1'b0;
      wait (num_done == trace_q.size());
      @(negedge clk);
      $display("Summary: %0d tests, %0d checks, %0d errors", trace_q.size(), check_count,
               error_count);
      if (error_count == 0) begin
        $display("Test OK");
      end else begin
        $display("Test FAILED");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire
